// ==== sources.f ====
cache_pkg.sv
stage_if.sv
way_store.sv
tag_lookup.sv
line_update.sv
l1_cache_top.sv
l1_cache_assertions.sv
tb_l1_cache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the L1 cache testbench with Verilator.
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_l1_cache -f sources.f -o sim_l1_cache
./obj_dir/sim_l1_cache +verilator+error+limit+100 | tee sim.log
if grep -q "all tests passed" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi

// ==== tb_l1_cache.sv ====
// Testbench for the two-way L1 line cache.
// Directed and random requests checked against a reference model.
`timescale 1ns/100ps
module tb_l1_cache;
    import cache_pkg::*;

    localparam int PERIOD   = 40;
    localparam int N_RANDOM = 60;
    localparam int N_REQ    = 20 + N_RANDOM;       // Directed ones rounded up.

    logic              clk, rst;
    logic              req_valid, req_ready, req_write;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic              resp_valid, resp_ready, resp_ok;
    logic [DATA_W-1:0] resp_rdata;
    logic              wb_valid, wb_ready;
    logic [ADDR_W-1:0] wb_addr;
    logic [DATA_W-1:0] wb_data;

    integer            seed = 32'hc99e;
    int                checks = 0;
    int                errors = 0;
    bit                stall_en = 1'b0;            // Random resp_ready gaps.
    bit                wb_seen  = 1'b0;            // Offer pending last cycle.
    line_t             model [int];                // Keyed by set*WAYS+way and present when valid.
    logic [WAY_W-1:0]  m_victim = '0;
    logic              exp_ok_q    [$];
    logic [DATA_W-1:0] exp_rdata_q [$];
    logic [ADDR_W-1:0] exp_wba_q   [$];
    logic [DATA_W-1:0] exp_wbd_q   [$];

    l1_cache_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic report_problem(input string what);
        errors++;
        $display("[ERROR] %s at %0t ns", what, $time);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h at %0t ns", name, got, exp, $time);
        end
    endtask

    function automatic logic [ADDR_W-1:0] make_addr(input int tag, input int index);
        return {TAG_W'(tag), INDEX_W'(index), OFFSET_W'(0)};
    endfunction

    // Reference model, updated in request order.
    task automatic predict(input logic write, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data);
        int               set_i;
        int               hit_key;
        int               free_key;
        int               vkey;
        logic [TAG_W-1:0] tag;
        set_i    = int'(addr[OFFSET_W +: INDEX_W]);
        tag      = addr[ADDR_W-1 -: TAG_W];
        hit_key  = -1;
        free_key = -1;
        for (int w = WAYS - 1; w >= 0; w--) begin  // Lowest empty way wins.
            if (!model.exists(set_i * WAYS + w)) free_key = set_i * WAYS + w;
            else if (model[set_i * WAYS + w].tag == tag) hit_key = set_i * WAYS + w;
        end
        if (!write) begin
            exp_ok_q.push_back(hit_key >= 0);
            if (hit_key >= 0) exp_rdata_q.push_back(model[hit_key].data);
            else exp_rdata_q.push_back('0);        // A miss answers zero.
        end else if (hit_key >= 0 || free_key >= 0) begin
            model[(hit_key >= 0) ? hit_key : free_key] = {1'b1, tag, data};
            exp_ok_q.push_back(1'b1);
            exp_rdata_q.push_back('0);
        end else begin
            vkey = set_i * WAYS + int'(m_victim);
            exp_wba_q.push_back({model[vkey].tag, addr[OFFSET_W +: INDEX_W], OFFSET_W'(0)});
            exp_wbd_q.push_back(model[vkey].data);
            exp_ok_q.push_back(wb_ready);          // wb_ready is held through an eviction.
            exp_rdata_q.push_back('0);
            if (wb_ready) begin
                model[vkey] = {1'b1, tag, data};
                m_victim    = WAY_W'((int'(m_victim) + 1) % WAYS);
            end
        end
    endtask

    task automatic send(input logic write, input logic [ADDR_W-1:0] addr,
                        input logic [DATA_W-1:0] data);
        predict(write, addr, data);
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = data;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);                            // Handshake edge.
        #2;
        req_valid = 1'b0;
    endtask

    task automatic drain();
        @(posedge clk);
        while (exp_ok_q.size() != 0) begin
            @(posedge clk);
        end
        #2;
    endtask

    // Checks on the response and write-back ports.
    always @(negedge clk) begin
        if (!rst && resp_valid && resp_ready) begin
            if (exp_ok_q.size() == 0) begin
                report_problem("response arrived with no request outstanding");
            end else begin
                check_value("resp_ok", 32'(resp_ok), 32'(exp_ok_q.pop_front()));
                check_value("resp_rdata", resp_rdata, exp_rdata_q.pop_front());
            end
        end
        if (!rst && wb_valid) begin
            if (exp_wba_q.size() == 0) begin
                report_problem("write-back offered that the model did not expect");
            end else begin
                check_value("wb_addr", 32'(wb_addr), 32'(exp_wba_q[0]));
                check_value("wb_data", wb_data, exp_wbd_q[0]);
                if (wb_ready) begin
                    void'(exp_wba_q.pop_front());
                    void'(exp_wbd_q.pop_front());
                end
            end
        end else if (wb_seen && exp_wba_q.size() != 0) begin
            void'(exp_wba_q.pop_front());          // Offer withdrawn on timeout.
            void'(exp_wbd_q.pop_front());
        end
        wb_seen = wb_valid && !wb_ready;
    end

    initial begin
        logic [31:0] r;
        logic        ready_next;
        resp_ready = 1'b1;
        forever begin
            @(negedge clk);
            r          = $random(seed);            // Next gap chosen half a cycle ahead.
            ready_next = !stall_en || r[0];
            @(posedge clk);
            #2;
            resp_ready = ready_next;
        end
    end

    initial begin
        logic [31:0] r;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        wb_ready  = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        send(1'b0, 16'h0040, '0);                  // Empty cache misses.
        send(1'b0, 16'hfffc, '0);
        send(1'b1, 16'h1234, 32'hdead_beef);       // Fill, read back, overwrite.
        send(1'b0, 16'h1234, '0);
        send(1'b1, 16'h1234, 32'h0bad_cafe);
        send(1'b0, 16'h1236, '0);                  // Same line, other offset.
        for (int t = 1; t <= 3; t++) send(1'b1, make_addr(t, 5), 32'h5a00_0000 + t);
        for (int t = 1; t <= 3; t++) send(1'b0, make_addr(t, 5), '0);
        send(1'b1, make_addr(4, 5), 32'h5a00_0004); // Second eviction takes way 1.
        drain();
        wb_ready = 1'b0;                           // Back side never accepts.
        send(1'b1, make_addr(5, 5), 32'h5a00_0005);
        drain();
        wb_ready = 1'b1;
        for (int t = 3; t <= 5; t++) send(1'b0, make_addr(t, 5), '0);
        send(1'b1, make_addr(6, 5), 32'h5a00_0006); // Victim pointer did not move.
        stall_en = 1'b1;
        for (int i = 0; i < N_RANDOM; i++) begin
            r = $random(seed);
            send(r[0], {TAG_W'(r[3:2]), INDEX_W'(r[5:4]), r[7:6]}, $random(seed));
        end
        drain();
        stall_en = 1'b0;
        repeat (4) @(posedge clk);
        if (exp_wba_q.size() != 0) report_problem("an expected write-back never appeared");
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, UUT.u_assert.fail_cnt);
        if (errors == 0 && UUT.u_assert.fail_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #((16 + N_REQ * (EVICT_TIMEOUT + 10)) * PERIOD);
        $display("Watchdog expired with %0d responses outstanding", exp_ok_q.size());
        $display("tests failed");
        $finish;
    end
endmodule

// ==== l1_cache_assertions.sv ====
// Port protocol and timing checks for the L1 cache, bound to its top level.
`timescale 1ns/100ps
module l1_cache_assertions (
    input logic                         clk,
    input logic                         rst,
    input logic                         req_valid,
    input logic                         req_ready,
    input logic                         resp_valid,
    input logic                         resp_ready,
    input logic                         resp_ok,
    input logic [cache_pkg::DATA_W-1:0] resp_rdata,
    input logic                         wb_valid,
    input logic                         wb_ready,
    input logic [cache_pkg::ADDR_W-1:0] wb_addr,
    input logic [cache_pkg::DATA_W-1:0] wb_data
);
    import cache_pkg::*;

    int fail_cnt = 0;   // Failed assertions so far.
    int in_flight_q;    // Requests taken, not yet answered.
    int wb_run_q;       // Earlier cycles of the current wb_valid run.

    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight_q <= 0;
            wb_run_q    <= 0;
        end else begin
            in_flight_q <= in_flight_q + int'(req_valid && req_ready)
                           - int'(resp_valid && resp_ready);
            wb_run_q    <= wb_valid ? wb_run_q + 1 : 0;
        end
    end

    resp_hold: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_ok) && $stable(resp_rdata))
    else begin
        $error("response dropped or changed while waiting for resp_ready");
        fail_cnt++;
    end

    wb_hold: assert property (@(posedge clk) disable iff (rst)
        wb_valid && !wb_ready |=> $stable(wb_addr) && $stable(wb_data))
    else begin
        $error("write-back payload changed while waiting for wb_ready");
        fail_cnt++;
    end

    // Both valids are low right after a reset cycle.
    reset_quiet: assert property (@(posedge clk) rst |=> !resp_valid && !wb_valid)
    else begin
        $error("valid output high in the cycle after reset");
        fail_cnt++;
    end

    // With nothing in flight, the answer needs at least two cycles.
    min_latency: assert property (@(posedge clk) disable iff (rst)
        req_valid && req_ready && in_flight_q == 0 |=> !resp_valid)
    else begin
        $error("response one cycle after its request");
        fail_cnt++;
    end

    wb_limit: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> wb_run_q < EVICT_TIMEOUT)
    else begin
        $error("wb_valid held past the eviction timeout");
        fail_cnt++;
    end
endmodule

bind l1_cache_top l1_cache_assertions u_assert (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp_ok    (resp_ok),
    .resp_rdata (resp_rdata),
    .wb_valid   (wb_valid),
    .wb_ready   (wb_ready),
    .wb_addr    (wb_addr),
    .wb_data    (wb_data)
);

// ==== l1_cache_top.sv ====
// Two-way set-associative write-back L1 line cache.
// Lookup and update stages around the way storage.
`timescale 1ns/100ps
module l1_cache_top (
    input  logic                         clk,
    input  logic                         rst,
    // Request channel.
    input  logic                         req_valid,
    output logic                         req_ready,
    input  logic                         req_write,
    input  logic [cache_pkg::ADDR_W-1:0] req_addr,
    input  logic [cache_pkg::DATA_W-1:0] req_wdata,
    // Response channel.
    output logic                         resp_valid,
    input  logic                         resp_ready,
    output logic                         resp_ok,
    output logic [cache_pkg::DATA_W-1:0] resp_rdata,
    // Write-back channel.
    output logic                         wb_valid,
    input  logic                         wb_ready,
    output logic [cache_pkg::ADDR_W-1:0] wb_addr,
    output logic [cache_pkg::DATA_W-1:0] wb_data
);
    import cache_pkg::*;

    logic [INDEX_W-1:0] rd_index;
    line_t [WAYS-1:0]   rd_lines;   // Set seen by the lookup stage.
    logic [INDEX_W-1:0] wr_index;
    logic [WAYS-1:0]    wr_en;
    line_t              wr_line;

    stage_if stg ();

    way_store u_store (
        .clk      (clk),
        .rst      (rst),
        .rd_index (rd_index),
        .rd_lines (rd_lines),
        .wr_index (wr_index),
        .wr_en    (wr_en),
        .wr_line  (wr_line)
    );

    tag_lookup u_lookup (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .rd_index  (rd_index),
        .rd_lines  (rd_lines),
        .out       (stg.lookup)
    );

    line_update u_update (
        .clk        (clk),
        .rst        (rst),
        .in         (stg.update),
        .wr_index   (wr_index),
        .wr_en      (wr_en),
        .wr_line    (wr_line),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_ok    (resp_ok),
        .resp_rdata (resp_rdata),
        .wb_valid   (wb_valid),
        .wb_ready   (wb_ready),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );
endmodule

// ==== line_update.sv ====
// Update stage of the L1 cache.
// Applies hit, fill or eviction and drives the response and write-back ports.
`timescale 1ns/100ps
module line_update (
    input  logic                          clk,
    input  logic                          rst,
    stage_if.update                       in,
    output logic [cache_pkg::INDEX_W-1:0] wr_index,
    output logic [cache_pkg::WAYS-1:0]    wr_en,
    output cache_pkg::line_t              wr_line,
    output logic                          resp_valid,
    input  logic                          resp_ready,
    output logic                          resp_ok,
    output logic [cache_pkg::DATA_W-1:0]  resp_rdata,
    output logic                          wb_valid,
    input  logic                          wb_ready,
    output logic [cache_pkg::ADDR_W-1:0]  wb_addr,
    output logic [cache_pkg::DATA_W-1:0]  wb_data
);
    import cache_pkg::*;

    logic [1:0]        state_q;
    logic [WAY_W-1:0]  victim_q;    // Round-robin victim, shared by all sets.
    logic [TMR_W-1:0]  tmr_q;       // Cycles spent waiting on wb_ready.
    cache_addr_u       addr_q;      // Write held across an eviction.
    logic [DATA_W-1:0] wdata_q;
    logic              take;        // Stage transfer.
    logic              store_now;   // Hit or fill, written at the transfer edge.
    logic              evict_need;  // Write to a full set with no hit.
    logic              evict_done;  // Write-back handshake.
    logic [WAY_W-1:0]  tgt_way;
    cache_addr_u       victim_addr;
    cache_addr_u       w_addr;

    assign in.ready   = (state_q == ST_IDLE);
    assign take       = in.valid && in.ready;
    assign store_now  = take && in.write && (in.hit || in.free);
    assign evict_need = take && in.write && !in.hit && !in.free;
    assign evict_done = (state_q == ST_EVICT) && wb_ready;

    assign resp_valid = (state_q == ST_RESP);
    assign wb_valid   = (state_q == ST_EVICT);

    // Victim line address, offset zero.
    always_comb begin
        victim_addr.f.tag    = in.ways_line[victim_q].tag;
        victim_addr.f.index  = in.addr.f.index;
        victim_addr.f.offset = '0;
    end

    // Write port. An accepted eviction overwrites the victim.
    assign tgt_way       = evict_done ? victim_q : (in.hit ? in.hit_way : in.free_way);
    assign w_addr        = evict_done ? addr_q : in.addr;
    assign wr_index      = w_addr.f.index;
    assign wr_line.valid = 1'b1;
    assign wr_line.tag   = w_addr.f.tag;
    assign wr_line.data  = evict_done ? wdata_q : in.wdata;
    assign wr_en         = (store_now || evict_done) ? (WAYS'(1) << tgt_way) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= ST_IDLE;
            victim_q <= '0;
            tmr_q    <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    tmr_q <= '0;
                    if (evict_need) begin
                        state_q <= ST_EVICT;
                    end else if (take) begin
                        state_q <= ST_RESP;      // Read, hit or fill is already done.
                    end
                end
                ST_EVICT: begin
                    if (wb_ready) begin
                        victim_q <= (victim_q == WAY_W'(WAYS - 1)) ? '0 : victim_q + 1'b1;
                        state_q  <= ST_RESP;
                    end else if (tmr_q == TMR_W'(EVICT_TIMEOUT - 1)) begin
                        state_q <= ST_RESP;      // Give up, cache untouched.
                    end else begin
                        tmr_q <= tmr_q + 1'b1;
                    end
                end
                ST_RESP: begin
                    if (resp_ready) state_q <= ST_IDLE;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Payloads. They stay put while their valid is waiting.
    always_ff @(posedge clk) begin
        if (take) begin
            addr_q     <= in.addr;
            wdata_q    <= in.wdata;
            wb_addr    <= victim_addr.word;
            wb_data    <= in.ways_line[victim_q].data;
            resp_ok    <= in.write ? (in.hit || in.free) : in.hit;
            resp_rdata <= (!in.write && in.hit) ? in.ways_line[in.hit_way].data : '0;
        end else if (state_q == ST_EVICT) begin
            resp_ok <= wb_ready;  // Set on the handshake, clear on timeout.
        end
    end
endmodule

// ==== tag_lookup.sv ====
// Lookup stage of the L1 cache.
// Holds one request, reads its set and compares tags.
`timescale 1ns/100ps
module tag_lookup (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   req_valid,
    output logic                                   req_ready,
    input  logic                                   req_write,
    input  logic [cache_pkg::ADDR_W-1:0]           req_addr,
    input  logic [cache_pkg::DATA_W-1:0]           req_wdata,
    output logic [cache_pkg::INDEX_W-1:0]          rd_index,
    input  cache_pkg::line_t [cache_pkg::WAYS-1:0] rd_lines,
    stage_if.lookup                                out
);
    import cache_pkg::*;

    logic              full_q;  // Register holds an item.
    logic              write_q;
    cache_addr_u       addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic              take;    // Request handshake.

    // Accept when empty or when the item leaves on this edge.
    assign req_ready = !full_q || out.ready;
    assign take      = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            full_q <= 1'b0;
        end else if (take) begin
            full_q <= 1'b1;
        end else if (out.ready) begin
            full_q <= 1'b0;          // Handed to the update stage.
        end
    end

    // Request payload.
    always_ff @(posedge clk) begin
        if (take) begin
            write_q     <= req_write;
            addr_q.word <= req_addr;
            wdata_q     <= req_wdata;
        end
    end

    assign rd_index      = addr_q.f.index;
    assign out.valid     = full_q;
    assign out.write     = write_q;
    assign out.addr      = addr_q;
    assign out.wdata     = wdata_q;
    assign out.ways_line = rd_lines;     // Victim data comes from here too.

    // Tag compare and free way search.
    always_comb begin
        out.hit      = 1'b0;
        out.hit_way  = '0;
        out.free     = 1'b0;
        out.free_way = '0;
        // Walk down so the lowest invalid way wins.
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (rd_lines[w].valid && rd_lines[w].tag == addr_q.f.tag) begin
                out.hit     = 1'b1;
                out.hit_way = WAY_W'(w);
            end
            if (!rd_lines[w].valid) begin
                out.free     = 1'b1;
                out.free_way = WAY_W'(w);
            end
        end
    end
endmodule

// ==== way_store.sv ====
// Line storage for all ways of the L1 cache.
// Set read is combinational, each way writes on the clock.
`timescale 1ns/100ps
module way_store (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [cache_pkg::INDEX_W-1:0]          rd_index, // Set looked up.
    output cache_pkg::line_t [cache_pkg::WAYS-1:0] rd_lines, // All ways of that set.
    input  logic [cache_pkg::INDEX_W-1:0]          wr_index, // Set written.
    input  logic [cache_pkg::WAYS-1:0]             wr_en,    // One bit per way.
    input  cache_pkg::line_t                       wr_line
);
    import cache_pkg::*;

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        logic [SETS-1:0]   valid_q;          // Valid bit per set.
        logic [TAG_W-1:0]  tag_mem  [SETS];
        logic [DATA_W-1:0] data_mem [SETS];

        always_ff @(posedge clk) begin
            if (rst) begin
                valid_q <= '0;
            end else if (wr_en[w]) begin
                valid_q[wr_index] <= wr_line.valid;
            end
        end

        // Tag and data array.
        always_ff @(posedge clk) begin
            if (wr_en[w]) begin
                tag_mem[wr_index]  <= wr_line.tag;
                data_mem[wr_index] <= wr_line.data;
            end
        end

        assign rd_lines[w].valid = valid_q[rd_index];  // Async read.
        assign rd_lines[w].tag   = tag_mem[rd_index];
        assign rd_lines[w].data  = data_mem[rd_index];
    end
endmodule

// ==== stage_if.sv ====
// Hand-over of one request and its lookup result from the tag stage to the update stage.
`timescale 1ns/100ps
interface stage_if;
    import cache_pkg::*;

    logic             valid;     // Lookup stage holds an item.
    logic             ready;     // Update stage is idle.
    logic             write;     // Write request, else read.
    cache_addr_u      addr;
    logic [DATA_W-1:0] wdata;
    logic             hit;       // Tag matched a valid line.
    logic [WAY_W-1:0] hit_way;
    logic             free;      // Set has an invalid way.
    logic [WAY_W-1:0] free_way;  // Lowest invalid way.
    line_t [WAYS-1:0] ways_line; // Whole set as read this cycle.

    // Tag stage side.
    modport lookup (
        output valid, write, addr, wdata, hit, hit_way, free, free_way, ways_line,
        input  ready
    );

    // Update stage side.
    modport update (
        input  valid, write, addr, wdata, hit, hit_way, free, free_way, ways_line,
        output ready
    );
endinterface

// ==== cache_pkg.sv ====
// Geometry, address decode and line layout shared by the two-way L1 line cache.
package cache_pkg;
    localparam int ADDR_W        = 16;                          // Byte address width.
    localparam int DATA_W        = 32;                          // One word per line.
    localparam int OFFSET_W      = 2;                           // Byte offset in a line.
    localparam int INDEX_W       = 4;                           // 16 sets.
    localparam int TAG_W         = ADDR_W - INDEX_W - OFFSET_W; // Remaining upper bits.
    localparam int SETS          = 1 << INDEX_W;
    localparam int WAYS          = 2;
    localparam int WAY_W         = 1;                           // Way number width.
    localparam int EVICT_TIMEOUT = 20;                          // Back side wait limit.
    localparam int TMR_W         = $clog2(EVICT_TIMEOUT);

    // Update stage states.
    localparam logic [1:0] ST_IDLE  = 2'd0; // Ready for the next item.
    localparam logic [1:0] ST_EVICT = 2'd1; // Victim offered on the write-back port.
    localparam logic [1:0] ST_RESP  = 2'd2; // Response held until taken.

    // Address split as the cache sees it.
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } addr_fields_t;

    // Flat word for the back side, fields for the lookup.
    typedef union packed {
        logic [ADDR_W-1:0] word;
        addr_fields_t      f;
    } cache_addr_u;

    // One stored line. Every valid line is dirty.
    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
    } line_t;
endpackage
